// ==== filelist.f ====
verilog/mem_share_pkg.sv
verilog/lzc.sv
verilog/rrarbiter.sv
verilog/req_issue_reg.sv
verilog/shared_ram.sv
verilog/resp_router.sv
verilog/mem_share_top.sv
tests/tb_mem_share.sv

// ==== tests/tb_mem_share.sv ====
// self-checking testbench that runs random requesters on mem_share_top against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_mem_share import mem_share_pkg::*; ();

    // stimulus phases
    localparam int MODE_IDLE  = 0;
    localparam int MODE_WRITE = 1;
    localparam int MODE_READ  = 2;
    localparam int MODE_MIX   = 3;
    localparam int N_READ = 200;
    localparam int N_MIX = 100;
    // write phase normally ends well before this
    localparam int WRITE_BUDGET = 160;
    // cycles spent in reset, order checks, enable and flush, the phases and the drain
    localparam int STIM_CYCLES = 4 + 5 + 3 + 1 + 1 + 4 + WRITE_BUDGET + N_READ + N_MIX + 8;
    localparam int TIMEOUT = 2 * STIM_CYCLES + 50;

    logic                             clk_i = 1'b0;
    logic                             rst_ni;
    logic                             en_i;
    logic                             flush_i;
    logic [NUM_PORTS-1:0]             req_i;
    mem_req_t [NUM_PORTS-1:0]         port_req_i;
    logic [NUM_PORTS-1:0]             ack_o;
    logic [NUM_PORTS-1:0]             rsp_valid_o;
    logic [NUM_PORTS-1:0][DATA_W-1:0] rsp_data_o;

    // stimulus control set by the main sequence
    int   mode = MODE_IDLE;
    int   ask_pct = 100;
    logic next_en = 1'b1;
    logic next_flush = 1'b0;
    int   wr_ptr [NUM_PORTS];
    // acks seen at the last falling edge
    logic [NUM_PORTS-1:0] acked = '0;

    // reference state
    logic [DATA_W-1:0] model_mem [MEM_DEPTH];
    logic [DATA_W-1:0] exp_data [NUM_PORTS];
    int                model_ptr = 0;
    // responses delayed by two cycles
    // each word holds the read flag above the data
    logic [NUM_PORTS-1:0] exp_vld_q [$];
    logic [DATA_W:0]      exp_word_q [$];
    int                   win;
    logic [NUM_PORTS-1:0] exp_ack;
    logic [NUM_PORTS-1:0] rsp_vld;
    logic [DATA_W:0]      rsp_word;
    logic [NUM_PORTS-1:0] cur_vld;
    logic [DATA_W:0]      cur_word;
    int                   cycle_cnt = 0;

    mem_share_top mem_share_top_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .en_i        (en_i),
        .flush_i     (flush_i),
        .req_i       (req_i),
        .port_req_i  (port_req_i),
        .ack_o       (ack_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o)
    );

    always #4 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, act, exp);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // lowest asking index above ptr or else the lowest asking index
    // returns -1 when nothing is granted
    function automatic int ref_winner(input logic [NUM_PORTS-1:0] req, input logic en,
                                      input int ptr);
        int w;
        w = -1;
        if (en) begin
            for (int k = NUM_PORTS - 1; k >= 0; k--) begin
                if (req[k]) w = k;
            end
            for (int k = NUM_PORTS - 1; k > ptr; k--) begin
                if (req[k]) w = k;
            end
        end
        return w;
    endfunction

    function automatic logic ask_now(input int k);
        logic roll;
        roll = ($urandom % 100) < ask_pct;
        case (mode)
            MODE_WRITE: ask_now = roll && (wr_ptr[k] < 16);
            MODE_READ:  ask_now = roll;
            MODE_MIX:   ask_now = 1'b1;
            default:    ask_now = 1'b0;
        endcase
    endfunction

    // each port owns the 16 words whose upper address bits are its region
    task automatic build_req(input int k);
        logic [1:0] region;
        region = 2'((k + 1 + $urandom % 3) % NUM_PORTS);
        port_req_i[k].wdata = '0;
        if (mode == MODE_WRITE) begin
            port_req_i[k].we    = 1'b1;
            port_req_i[k].addr  = {2'(k), 4'(wr_ptr[k])};
            port_req_i[k].wdata = {8'(k), 8'(wr_ptr[k]), 16'($urandom)};
            wr_ptr[k]++;
        end else if (mode == MODE_READ) begin
            port_req_i[k].we   = 1'b0;
            port_req_i[k].addr = {region, 4'($urandom)};
        end else if (k < 2) begin
            // ports 0 and 1 only write in mixed traffic
            port_req_i[k].we    = 1'b1;
            port_req_i[k].addr  = {2'(k), 4'($urandom)};
            port_req_i[k].wdata = {8'(k), 24'($urandom)};
        end else begin
            port_req_i[k].we   = 1'b0;
            port_req_i[k].addr = 6'($urandom);
        end
    endtask

    // one cycle of stimulus where acked requests drop
    task automatic drive_step();
        @(posedge clk_i);
        #1;
        en_i    = next_en;
        flush_i = next_flush;
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (acked[k]) req_i[k] = 1'b0;
            if (!req_i[k] && ask_now(k)) begin
                build_req(k);
                req_i[k] = 1'b1;
            end
        end
    endtask

    // grants must walk the ports in order starting at first
    task automatic expect_order(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            drive_step();
            @(negedge clk_i);
            check_value("ack_o", ack_o, 64'(1) << ((first + i) % NUM_PORTS));
        end
    endtask

    function automatic int writes_left();
        int n;
        n = 0;
        for (int k = 0; k < NUM_PORTS; k++) n += 16 - wr_ptr[k];
        return n;
    endfunction

    // compare in the middle of the cycle when inputs have settled
    always @(negedge clk_i) begin
        if (rst_ni) begin
            // a port granted last cycle waits while someone else asks
            if ((req_i & ~acked) != '0) check_value("ack_o repeat", ack_o & acked, '0);
            win = ref_winner(req_i, en_i, model_ptr);
            exp_ack = (win >= 0) ? NUM_PORTS'(1) << win : '0;
            check_value("ack_o", ack_o, exp_ack);
            rsp_vld  = '0;
            rsp_word = '0;
            if (win >= 0) begin
                rsp_vld[win] = 1'b1;
                // accesses reach the RAM in grant order
                if (port_req_i[win].we) model_mem[port_req_i[win].addr] = port_req_i[win].wdata;
                else rsp_word = {1'b1, model_mem[port_req_i[win].addr]};
            end
            exp_vld_q.push_back(rsp_vld);
            exp_word_q.push_back(rsp_word);
            cur_vld  = exp_vld_q.pop_front();
            cur_word = exp_word_q.pop_front();
            for (int k = 0; k < NUM_PORTS; k++) begin
                if (cur_vld[k] && cur_word[DATA_W]) exp_data[k] = cur_word[DATA_W-1:0];
            end
            check_value("rsp_valid_o", rsp_valid_o, cur_vld);
            for (int k = 0; k < NUM_PORTS; k++) begin
                check_value($sformatf("rsp_data_o[%0d]", k), rsp_data_o[k], exp_data[k]);
            end
            if (flush_i) model_ptr = 0;
            else if (win >= 0) model_ptr = win;
            acked = ack_o;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(61));
        rst_ni     = 1'b0;
        en_i       = 1'b0;
        flush_i    = 1'b0;
        req_i      = '0;
        port_req_i = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            wr_ptr[k]   = 0;
            exp_data[k] = '0;
        end
        // pipeline is empty out of reset
        repeat (2) begin
            exp_vld_q.push_back('0);
            exp_word_q.push_back('0);
        end
        repeat (4) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        // everyone asking with pointer 0 so port 1 goes first
        mode = MODE_WRITE;
        expect_order(1, 5);
        // disabled cycles leave the pointer at 1
        next_en = 1'b0;
        repeat (3) drive_step();
        next_en = 1'b1;
        expect_order(2, 1);
        next_en    = 1'b0;
        next_flush = 1'b1;
        drive_step();
        next_flush = 1'b0;
        next_en    = 1'b1;
        expect_order(1, 4);
        // fill every port's region
        ask_pct = 75;
        while (req_i != '0 || writes_left() != 0) drive_step();
        mode    = MODE_READ;
        ask_pct = 50;
        repeat (N_READ) drive_step();
        mode = MODE_MIX;
        repeat (N_MIX) drive_step();
        // let held requests and the pipeline drain
        mode = MODE_IDLE;
        repeat (8) drive_step();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/mem_share_top.sv ====
// top level of the shared memory, ties the arbiter, issue register, RAM and router together
`timescale 1ns/1ps
`default_nettype none

module mem_share_top import mem_share_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             en_i,
    input  logic                             flush_i,
    input  logic [NUM_PORTS-1:0]             req_i,
    input  mem_req_t [NUM_PORTS-1:0]         port_req_i,
    output logic [NUM_PORTS-1:0]             ack_o,
    output logic [NUM_PORTS-1:0]             rsp_valid_o,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] rsp_data_o
);

    // grant of the current cycle
    logic              arb_vld;
    logic [PORT_W-1:0] arb_idx;
    // pipeline toward and back from the RAM
    mem_issue_t        issue;
    mem_rsp_t          rsp;

    rrarbiter #(
        .NUM_REQ (NUM_PORTS)
    ) i_rrarbiter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .en_i    (en_i),
        .req_i   (req_i),
        .ack_o   (ack_o),
        .vld_o   (arb_vld),
        .idx_o   (arb_idx)
    );

    req_issue_reg i_req_issue_reg (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .vld_i      (arb_vld),
        .idx_i      (arb_idx),
        .port_req_i (port_req_i),
        .issue_o    (issue)
    );

    shared_ram i_shared_ram (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .issue_i (issue),
        .rsp_o   (rsp)
    );

    resp_router i_resp_router (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rsp_i       (rsp),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o)
    );

endmodule

`default_nettype wire

// ==== verilog/resp_router.sv ====
// routes RAM responses back to their port as a pulse and keeps each port's last read data
`timescale 1ns/1ps
`default_nettype none

module resp_router import mem_share_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  mem_rsp_t                         rsp_i,
    output logic [NUM_PORTS-1:0]             rsp_valid_o,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] rsp_data_o
);

    // per-port hold of the last read data
    logic [NUM_PORTS-1:0][DATA_W-1:0] data_q;
    // read responses only, writes leave the hold alone
    logic [NUM_PORTS-1:0]             rd_hit;

    always_comb begin
        for (int k = 0; k < NUM_PORTS; k++) begin
            rsp_valid_o[k] = rsp_i.valid & (int'(rsp_i.tag) == k);
            rd_hit[k]      = rsp_valid_o[k] & ~rsp_i.we;
            // bypass so the data is visible in the pulse cycle
            rsp_data_o[k]  = rd_hit[k] ? rsp_i.rdata : data_q[k];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_q <= '0;
        end else begin
            for (int k = 0; k < NUM_PORTS; k++) begin
                if (rd_hit[k]) begin
                    data_q[k] <= rsp_i.rdata;
                end
            end
        end
    end

    // at most one port sees a response per cycle
    a_rsp_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(rsp_valid_o))
        else $error("rsp_valid_o not one-hot");

endmodule

`default_nettype wire

// ==== verilog/shared_ram.sv ====
// single-port synchronous RAM shared by all ports, returns the access tag one cycle later
`timescale 1ns/1ps
`default_nettype none

module shared_ram import mem_share_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  mem_issue_t issue_i,
    output mem_rsp_t   rsp_o
);

    // storage, starts uninitialized
    logic [DATA_W-1:0] mem_q [MEM_DEPTH];
    logic              valid_q;
    logic [PORT_W-1:0] tag_q;
    logic              we_q;
    logic [DATA_W-1:0] rdata_q;

    // response valid tracks issue valid with one cycle delay
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i.valid;
        end
    end

    // one access per cycle, read or write
    always_ff @(posedge clk_i) begin
        if (issue_i.valid) begin
            tag_q <= issue_i.tag;
            we_q  <= issue_i.req.we;
            if (issue_i.req.we) begin
                mem_q[issue_i.req.addr] <= issue_i.req.wdata;
            end else begin
                rdata_q <= mem_q[issue_i.req.addr];
            end
        end
    end

    assign rsp_o = '{valid: valid_q, tag: tag_q, we: we_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== verilog/req_issue_reg.sv ====
// registers the granted port's request with its tag, feeding the shared RAM
`timescale 1ns/1ps
`default_nettype none

module req_issue_reg import mem_share_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      vld_i,
    input  logic [PORT_W-1:0]         idx_i,
    input  mem_req_t [NUM_PORTS-1:0]  port_req_i,
    output mem_issue_t                issue_o
);

    // winner's request, picked by the arbiter index
    mem_req_t          sel_req;
    logic              valid_q;
    logic [PORT_W-1:0] tag_q;
    mem_req_t          req_q;

    assign sel_req = port_req_i[idx_i];

    // valid is the only control bit here
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= vld_i;
        end
    end

    // payload only loads on a grant
    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            tag_q <= idx_i;
            req_q <= sel_req;
        end
    end

    assign issue_o = '{valid: valid_q, tag: tag_q, req: req_q};

    // a grant shows up one cycle later with the granted port as tag
    a_issue_tag : assert property (@(posedge clk_i) disable iff (!rst_ni)
        vld_i |=> (issue_o.valid && (issue_o.tag == $past(idx_i))))
        else $error("issued tag differs from granted index");

endmodule

`default_nettype wire

// ==== verilog/rrarbiter.sv ====
// round-robin arbiter with lookahead, grants one requester per cycle with enable and flush
`timescale 1ns/1ps
`default_nettype none

module rrarbiter #(
    parameter int unsigned NUM_REQ = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // clears the round-robin pointer
    input  logic                       flush_i,
    // no grant at all while low
    input  logic                       en_i,
    input  logic [NUM_REQ-1:0]         req_i,
    output logic [NUM_REQ-1:0]         ack_o,
    output logic                       vld_o,
    output logic [$clog2(NUM_REQ)-1:0] idx_o
);

    localparam int unsigned SEL_W = $clog2(NUM_REQ);

    // next winner and last granted index
    logic [SEL_W-1:0] arb_sel_d;
    logic [SEL_W-1:0] arb_sel_q;

    if (NUM_REQ == 2) begin : g_two
        // pointer 0 favours port 1, pointer 1 favours port 0
        assign arb_sel_d = req_i[1] & (~arb_sel_q[0] | ~req_i[0]);
        assign vld_o     = en_i & (|req_i);
        assign ack_o[0]  = en_i & req_i[0] & (arb_sel_q[0] | ~req_i[1]);
        assign ack_o[1]  = en_i & arb_sel_d[0];
    end else begin : g_multi
        // requests strictly above the pointer
        logic [NUM_REQ-1:0] masked_above;
        // requests at or below the pointer, used on wrap
        logic [NUM_REQ-1:0] masked_wrap;
        logic [SEL_W-1:0]   above_idx;
        logic [SEL_W-1:0]   wrap_idx;
        logic               no_above;
        logic               no_wrap;

        always_comb begin
            for (int k = 0; k < NUM_REQ; k++) begin
                masked_above[k] = req_i[k] & (k > int'(arb_sel_q));
                masked_wrap[k]  = req_i[k] & (k <= int'(arb_sel_q));
            end
        end

        // first asking port above the last winner
        lzc #(
            .WIDTH (NUM_REQ)
        ) i_above_ff1 (
            .in_i    (masked_above),
            .cnt_o   (above_idx),
            .empty_o (no_above)
        );

        // first asking port from the bottom, after wrap
        lzc #(
            .WIDTH (NUM_REQ)
        ) i_wrap_ff1 (
            .in_i    (masked_wrap),
            .cnt_o   (wrap_idx),
            .empty_o (no_wrap)
        );

        // the two halves cover the whole vector, so both empty means no request
        assign vld_o     = en_i & ~(no_above & no_wrap);
        assign arb_sel_d = no_above ? wrap_idx : above_idx;

        always_comb begin
            for (int k = 0; k < NUM_REQ; k++) begin
                ack_o[k] = vld_o & (int'(arb_sel_d) == k);
            end
        end
    end

    assign idx_o = arb_sel_d;

    // pointer moves only on a real grant
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arb_sel_q <= '0;
        end else if (flush_i) begin
            arb_sel_q <= '0;
        end else if (vld_o) begin
            arb_sel_q <= arb_sel_d;
        end
    end

    initial begin
        assert (NUM_REQ >= 2) else $fatal(1, "rrarbiter needs at least 2 requesters");
    end

    // grant and valid always agree
    a_ack_vld : assert property (@(posedge clk_i) disable iff (!rst_ni)
        |ack_o |-> vld_o)
        else $error("ack without vld");
    a_vld_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
        vld_o |-> |ack_o)
        else $error("vld without ack");
    // disabled arbiter grants nothing
    a_no_en : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !en_i |-> (ack_o == '0))
        else $error("ack while disabled");
    // index output points at the granted port
    a_ack_idx : assert property (@(posedge clk_i) disable iff (!rst_ni)
        vld_o |-> ack_o[idx_o])
        else $error("idx_o and ack_o mismatch");
    a_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(ack_o))
        else $error("ack_o not one-hot");

endmodule

`default_nettype wire

// ==== verilog/lzc.sv ====
// lowest-set-bit finder tree, used by the arbiter as its first-one finder
`timescale 1ns/1ps
`default_nettype none

module lzc #(
    parameter int unsigned WIDTH = 4
) (
    input  logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    output logic                     empty_o
);

    // tree depth and padded leaf count
    localparam int unsigned CNT_W = $clog2(WIDTH);
    localparam int unsigned NUM_LEAF = 2 ** CNT_W;

    // input padded up to a power of two, upper bits never set
    logic [NUM_LEAF-1:0] in_pad;
    // heap-ordered nodes, node n has children 2n+1 (lower bits) and 2n+2
    logic [NUM_LEAF-2:0] node_vld;
    logic [CNT_W-1:0]    node_idx [NUM_LEAF-1];

    assign in_pad = NUM_LEAF'(in_i);

    for (genvar lvl = 0; lvl < CNT_W; lvl++) begin : g_level
        for (genvar n = 0; n < 2 ** lvl; n++) begin : g_node
            localparam int unsigned NODE = 2 ** lvl - 1 + n;
            if (lvl == CNT_W - 1) begin : g_leaf
                // leaf looks at one pair of input bits
                assign node_vld[NODE] = in_pad[2*n] | in_pad[2*n+1];
                assign node_idx[NODE] = in_pad[2*n] ? CNT_W'(2 * n) : CNT_W'(2 * n + 1);
            end else begin : g_inner
                // lower half wins whenever it has a set bit
                assign node_vld[NODE] = node_vld[2*NODE+1] | node_vld[2*NODE+2];
                assign node_idx[NODE] = node_vld[2*NODE+1] ? node_idx[2*NODE+1]
                                                           : node_idx[2*NODE+2];
            end
        end
    end

    // root carries the result
    assign cnt_o   = node_idx[0];
    assign empty_o = ~node_vld[0];

endmodule

`default_nettype wire

// ==== verilog/mem_share_pkg.sv ====
// shared constants and request/response structs for the shared memory design, imported by the RTL
`default_nettype none

package mem_share_pkg;

    // number of requesters sharing the memory
    localparam int unsigned NUM_PORTS = 4;
    // width of a port index / tag
    localparam int unsigned PORT_W = $clog2(NUM_PORTS);

    // word address width, gives a 64 word RAM
    localparam int unsigned ADDR_W = 6;
    localparam int unsigned MEM_DEPTH = 2 ** ADDR_W;
    localparam int unsigned DATA_W = 32;

    // request held by a requester until acked, 39 bits
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // registered winner toward the RAM, 42 bits
    typedef struct packed {
        logic              valid;
        logic [PORT_W-1:0] tag;
        mem_req_t          req;
    } mem_issue_t;

    // registered RAM response, 36 bits
    // we is passed through so the router can skip write responses
    typedef struct packed {
        logic              valid;
        logic [PORT_W-1:0] tag;
        logic              we;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire
